/* vlog.f */
source/rv_pkg.sv
source/pipe_reg.sv
source/fetch_decode.sv
source/regfile.sv
source/hazard_unit.sv
source/execute_unit.sv
source/mem_wb_unit.sv
source/rv_core.sv
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, verdict from sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module rv_core_tb -o rv_core_sim > sim.log 2>&1 \
    && ./obj_dir/rv_core_sim >> sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log
! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log && echo "run passed" \
    || { cat sim.log; exit 1; }

/* tests/core_stimulus.txt */
# I <byte addr> <instruction word>       program, ends in a jump to itself
# D <byte addr> <data word>              preloaded data
# S <byte addr> <data> <size>            expected store in order, size 0 byte 1 half 2 word
I 00 123450b7  lui   x1, 0x12345
I 04 67808093  addi  x1, x1, 0x678
I 08 fff0c113  xori  x2, x1, -1
I 0c 002081b3  add   x3, x1, x2
I 10 00001217  auipc x4, 0x1
I 14 10302023  sw    x3, 0x100(x0)
I 18 10402223  sw    x4, 0x104(x0)
I 1c 20100283  lb    x5, 0x201(x0)
I 20 10502423  sw    x5, 0x108(x0)
I 24 20201303  lh    x6, 0x202(x0)
I 28 20002383  lw    x7, 0x200(x0)
I 2c 20004403  lbu   x8, 0x200(x0)
I 30 20205483  lhu   x9, 0x202(x0)
I 34 10602623  sw    x6, 0x10c(x0)
I 38 10702823  sw    x7, 0x110(x0)
I 3c 10802a23  sw    x8, 0x114(x0)
I 40 10902c23  sw    x9, 0x118(x0)
I 44 10601e23  sh    x6, 0x11c(x0)
I 48 12500023  sb    x5, 0x120(x0)
I 4c 00108463  beq   x1, x1, +8   taken
I 50 1e002823  sw    x0, 0x1f0(x0)   wrong path
I 54 00109463  bne   x1, x1, +8   not taken
I 58 00150513  addi  x10, x10, 1
I 5c 00114463  blt   x2, x1, +8   taken
I 60 1e002823  sw    x0, 0x1f0(x0)   wrong path
I 64 00115463  bge   x2, x1, +8   not taken
I 68 00150513  addi  x10, x10, 1
I 6c 0020e463  bltu  x1, x2, +8   taken
I 70 1e002823  sw    x0, 0x1f0(x0)   wrong path
I 74 0020f463  bgeu  x1, x2, +8   not taken
I 78 00150513  addi  x10, x10, 1
I 7c 008005ef  jal   x11, +8
I 80 1e002823  sw    x0, 0x1f0(x0)   wrong path
I 84 00000617  auipc x12, 0
I 88 010606e7  jalr  x13, 16(x12)
I 8c 1e002823  sw    x0, 0x1f0(x0)   wrong path
I 90 1e002823  sw    x0, 0x1f0(x0)   wrong path
I 94 12a02223  sw    x10, 0x124(x0)
I 98 12b02423  sw    x11, 0x128(x0)
I 9c 12d02623  sw    x13, 0x12c(x0)
I a0 0000006f  jal   x0, 0
D 200 8091a2b3
S 100 ffffffff 2
S 104 00001010 2
S 108 ffffffa2 2
S 10c ffff8091 2
S 110 8091a2b3 2
S 114 000000b3 2
S 118 00008091 2
S 11c 00008091 1
S 120 000000a2 0
S 124 00000003 2
S 128 00000080 2
S 12c 0000008c 2

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int    MEM_WORDS = 256;                      // 1 KiB per memory
    localparam string STIM_FILE = "tests/core_stimulus.txt";

    logic           clk        = 1'b0;
    logic           rst_n      = 1'b0;
    rv_pkg::word_t  imem_addr;
    rv_pkg::word_t  imem_rdata;
    logic           dmem_req;
    logic           dmem_we;
    rv_pkg::word_t  dmem_addr;
    rv_pkg::word_t  dmem_wdata;
    rv_pkg::tsize_e dmem_size;
    rv_pkg::word_t  dmem_rdata = '0;
    logic           dmem_done  = 1'b0;

    rv_pkg::word_t  imem [MEM_WORDS];
    rv_pkg::word_t  dmem [MEM_WORDS];
    rv_pkg::word_t  exp_addr [$];   // expected stores, oldest first
    rv_pkg::word_t  exp_data [$];
    rv_pkg::tsize_e exp_size [$];

    integer seed;
    int     prog_words;
    int     cycles;
    int     limit;
    int     wait_left;
    logic   active;                 // access accepted, wait states running

    rv_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_size_o  (dmem_size),
        .dmem_rdata_i (dmem_rdata),
        .dmem_done_i  (dmem_done)
    );

    initial begin
        forever #20 clk = ~clk;     // 40 ns period
    end

    assign imem_rdata = imem[imem_addr[9:2]]; // same-cycle answer

    // --------------------------------------------------
    // reporting and compares
    // --------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input rv_pkg::tsize_e got,
                              input rv_pkg::tsize_e exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    function automatic rv_pkg::word_t lane_mask(input rv_pkg::tsize_e size);
        case (size)
            rv_pkg::BYTE: return 32'h0000_00ff;
            rv_pkg::HALF: return 32'h0000_ffff;
            default:      return 32'hffff_ffff;
        endcase
    endfunction

    task automatic load_stimulus();
        int            fd;
        string         line;
        rv_pkg::word_t a;
        rv_pkg::word_t d;
        logic [31:0]   s;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file");
        end else begin
            while ($fgets(line, fd)) begin
                if ($sscanf(line, "I %h %h", a, d) == 2) begin
                    imem[a[9:2]] = d;
                    prog_words++;
                end else if ($sscanf(line, "D %h %h", a, d) == 2) begin
                    dmem[a[9:2]] = d;
                end else if ($sscanf(line, "S %h %h %h", a, d, s) == 3) begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_size.push_back(rv_pkg::tsize_e'(s[1:0]));
                end
            end
            $fclose(fd);
        end
    endtask

    // one access at the done edge, data right aligned both ways
    task automatic serve_access();
        int            idx;
        logic [4:0]    sh;
        rv_pkg::word_t mask;
        idx  = int'(dmem_addr[9:2]);
        sh   = {dmem_addr[1:0], 3'b000};
        mask = lane_mask(dmem_size);
        if (!dmem_we) begin
            dmem_rdata <= dmem[idx] >> sh;
        end else if (exp_addr.size() == 0) begin
            fail_run($sformatf("store to %h at %0t ns came after the last expected store",
                               dmem_addr, $time));
        end else begin
            check_word("dmem_addr_o", dmem_addr, exp_addr[0]);
            check_size("dmem_size_o", dmem_size, exp_size[0]);
            check_word("dmem_wdata_o", dmem_wdata & mask, exp_data[0] & mask);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_size.pop_front());
            dmem[idx] = (dmem[idx] & ~(mask << sh)) | ((dmem_wdata & mask) << sh);
        end
    endtask

    // --------------------------------------------------
    // data memory, 0 to 3 wait states
    // --------------------------------------------------
    always @(posedge clk) begin
        dmem_done <= 1'b0;
        if (!rst_n || !dmem_req || dmem_done) begin
            active = 1'b0;               // idle, or request just ended
        end else begin
            if (!active) begin
                active    = 1'b1;
                wait_left = $random(seed) & 32'd3;
            end
            if (wait_left == 0) begin
                serve_access();
                dmem_done <= 1'b1;
                active = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        seed       = 32'h7df44c9e;
        prog_words = 0;
        active     = 1'b0;
        wait_left  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = rv_pkg::NOP_INSTR | (rv_pkg::word_t'(i) << 20); // addi x0, x0, i
            dmem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000; // scrambled per word
        end
        load_stimulus();
        limit = 64 * prog_words + 200;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("dmem_req_o", {31'b0, dmem_req}, '0);
        check_word("imem_addr_o", imem_addr, rv_pkg::RESET_PC);

        cycles = 0;
        while (exp_addr.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run($sformatf("timeout after %0d cycles with %0d stores still missing",
                                   cycles, exp_addr.size()));
            end
        end
        repeat (40) @(posedge clk);     // any late extra store shows up here
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic           clk,
    input  logic           rst_n,
    output rv_pkg::word_t  imem_addr_o,
    input  rv_pkg::word_t  imem_rdata_i,
    output logic           dmem_req_o,
    output logic           dmem_we_o,
    output rv_pkg::word_t  dmem_addr_o,
    output rv_pkg::word_t  dmem_wdata_o,
    output rv_pkg::tsize_e dmem_size_o,
    input  rv_pkg::word_t  dmem_rdata_i,
    input  logic           dmem_done_i
);

    // stage payloads, d side and q side
    rv_pkg::if_id_t    if_id_d;
    rv_pkg::if_id_t    if_id_q;
    rv_pkg::id_ex_t    id_ex_d;
    rv_pkg::id_ex_t    id_ex_q;
    rv_pkg::ex_ma_t    ex_ma_d;
    rv_pkg::ex_ma_t    ex_ma_q;
    rv_pkg::ma_wb_t    ma_wb_d;
    rv_pkg::ma_wb_t    ma_wb_q;

    rv_pkg::word_t     rf_r1;
    rv_pkg::word_t     rf_r2;
    rv_pkg::word_t     wb_data;
    rv_pkg::word_t     target;
    rv_pkg::reg_addr_t rf_rd;
    logic              rf_wr;
    logic              redirect;
    logic              mem_busy;

    // pipeline control
    logic flush;
    logic stall_pc;
    logic stall_if_id;
    logic stall_id_ex;
    logic stall_ex_ma;
    logic bubble_id_ex;
    logic bubble_ma_wb;

    fetch_decode fetch_decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_pc),
        .redirect_i   (redirect),
        .target_i     (target),
        .imem_rdata_i (imem_rdata_i),
        .imem_addr_o  (imem_addr_o),
        .if_id_o      (if_id_d)
    );

    pipe_reg #(.payload_t(rv_pkg::if_id_t)) if_id_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_i  (flush),
        .stall_i  (stall_if_id),
        .bubble_i (1'b0),
        .d_i      (if_id_d),
        .q_o      (if_id_q)
    );

    regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_i    (if_id_q.rs1),
        .rs2_i    (if_id_q.rs2),
        .wr_i     (rf_wr),
        .rd_i     (rf_rd),
        .wrdata_i (wb_data),
        .r1_o     (rf_r1),
        .r2_o     (rf_r2)
    );

    hazard_unit hazard_unit_i (
        .if_id_i        (if_id_q),
        .id_ex_i        (id_ex_q),
        .ex_ma_i        (ex_ma_q),
        .ma_wb_i        (ma_wb_q),
        .rf_r1_i        (rf_r1),
        .rf_r2_i        (rf_r2),
        .wb_data_i      (wb_data),
        .redirect_i     (redirect),
        .mem_busy_i     (mem_busy),
        .id_ex_d_o      (id_ex_d),
        .flush_o        (flush),
        .stall_pc_o     (stall_pc),
        .stall_if_id_o  (stall_if_id),
        .stall_id_ex_o  (stall_id_ex),
        .stall_ex_ma_o  (stall_ex_ma),
        .bubble_id_ex_o (bubble_id_ex),
        .bubble_ma_wb_o (bubble_ma_wb)
    );

    pipe_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_i  (flush),
        .stall_i  (stall_id_ex),
        .bubble_i (bubble_id_ex),
        .d_i      (id_ex_d),
        .q_o      (id_ex_q)
    );

    execute_unit execute_unit_i (
        .id_ex_i   (id_ex_q),
        .ex_ma_d_o (ex_ma_d)
    );

    pipe_reg #(.payload_t(rv_pkg::ex_ma_t)) ex_ma_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_i  (flush),
        .stall_i  (stall_ex_ma),
        .bubble_i (1'b0),
        .d_i      (ex_ma_d),
        .q_o      (ex_ma_q)
    );

    mem_wb_unit mem_wb_unit_i (
        .ex_ma_i      (ex_ma_q),
        .ma_wb_i      (ma_wb_q),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_done_i  (dmem_done_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_size_o  (dmem_size_o),
        .ma_wb_d_o    (ma_wb_d),
        .mem_busy_o   (mem_busy),
        .redirect_o   (redirect),
        .target_o     (target),
        .rf_wr_o      (rf_wr),
        .rf_rd_o      (rf_rd),
        .wb_data_o    (wb_data)
    );

    // never stalled, drains while the access waits
    pipe_reg #(.payload_t(rv_pkg::ma_wb_t)) ma_wb_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_i  (flush),
        .stall_i  (1'b0),
        .bubble_i (bubble_ma_wb),
        .d_i      (ma_wb_d),
        .q_o      (ma_wb_q)
    );

endmodule

/* source/mem_wb_unit.sv */
`timescale 1ns/1ps

module mem_wb_unit (
    input  rv_pkg::ex_ma_t    ex_ma_i,
    input  rv_pkg::ma_wb_t    ma_wb_i,
    input  rv_pkg::word_t     dmem_rdata_i,
    input  logic              dmem_done_i,
    output logic              dmem_req_o,
    output logic              dmem_we_o,
    output rv_pkg::word_t     dmem_addr_o,
    output rv_pkg::word_t     dmem_wdata_o,
    output rv_pkg::tsize_e    dmem_size_o,
    output rv_pkg::ma_wb_t    ma_wb_d_o,
    output logic              mem_busy_o,
    output logic              redirect_o,
    output rv_pkg::word_t     target_o,
    output logic              rf_wr_o,
    output rv_pkg::reg_addr_t rf_rd_o,
    output rv_pkg::word_t     wb_data_o
);

    rv_pkg::opcode_e ma_op;
    rv_pkg::opcode_e wb_op;
    rv_pkg::word_t   ld_data;   // extended load value

    assign ma_op = rv_pkg::opcode_e'(ex_ma_i.instruction[6:2]);
    assign wb_op = rv_pkg::opcode_e'(ma_wb_i.instruction[6:2]);

    // --------------------------------------------------
    // data bus, held stable until done
    // --------------------------------------------------
    assign dmem_req_o   = (ex_ma_i.mem_rd | ex_ma_i.mem_wr) & ~redirect_o; // wrong path
    assign dmem_we_o    = ex_ma_i.mem_wr;
    assign dmem_addr_o  = ex_ma_i.mem_addr;
    assign dmem_wdata_o = ex_ma_i.rf_r2;      // right aligned
    assign dmem_size_o  = ex_ma_i.tsize;
    assign mem_busy_o   = dmem_req_o & ~dmem_done_i;

    always_comb begin
        ma_wb_d_o              = '0;
        ma_wb_d_o.instruction  = ex_ma_i.instruction;
        ma_wb_d_o.pc           = ex_ma_i.pc;
        ma_wb_d_o.rd           = ex_ma_i.rd;
        ma_wb_d_o.rf_wr        = ex_ma_i.rf_wr;
        ma_wb_d_o.alu_out      = ex_ma_i.alu_out;
        ma_wb_d_o.mem_rdata    = dmem_rdata_i;   // sampled on the done edge
        ma_wb_d_o.branch_taken = ex_ma_i.branch_taken;
        case (ma_op)
            rv_pkg::BRANCH: ma_wb_d_o.next_pc = ex_ma_i.branch_taken
                                ? ex_ma_i.pc + rv_pkg::imm_b(ex_ma_i.instruction)
                                : ex_ma_i.pc + 32'd4;
            rv_pkg::JAL:    ma_wb_d_o.next_pc = ex_ma_i.pc + rv_pkg::imm_j(ex_ma_i.instruction);
            rv_pkg::JALR:   ma_wb_d_o.next_pc = ex_ma_i.mem_addr & ~32'd1;
            default:        ma_wb_d_o.next_pc = ex_ma_i.pc + 32'd4;
        endcase
    end

    // --------------------------------------------------
    // write-back
    // --------------------------------------------------
    always_comb begin
        case (ma_wb_i.instruction[14:12])
            3'b000:  ld_data = {{24{ma_wb_i.mem_rdata[7]}}, ma_wb_i.mem_rdata[7:0]};   // lb
            3'b001:  ld_data = {{16{ma_wb_i.mem_rdata[15]}}, ma_wb_i.mem_rdata[15:0]}; // lh
            3'b100:  ld_data = {24'b0, ma_wb_i.mem_rdata[7:0]};                        // lbu
            3'b101:  ld_data = {16'b0, ma_wb_i.mem_rdata[15:0]};                       // lhu
            default: ld_data = ma_wb_i.mem_rdata;
        endcase
    end

    always_comb begin
        case (wb_op)
            rv_pkg::LOAD:             wb_data_o = ld_data;
            rv_pkg::LUI:              wb_data_o = rv_pkg::imm_u(ma_wb_i.instruction);
            rv_pkg::AUIPC:            wb_data_o = ma_wb_i.pc + rv_pkg::imm_u(ma_wb_i.instruction);
            rv_pkg::JAL, rv_pkg::JALR: wb_data_o = ma_wb_i.pc + 32'd4; // link
            default:                  wb_data_o = ma_wb_i.alu_out;
        endcase
    end

    assign rf_wr_o    = ma_wb_i.rf_wr;
    assign rf_rd_o    = ma_wb_i.rd;
    assign redirect_o = (wb_op inside {rv_pkg::JAL, rv_pkg::JALR})
                      | ((wb_op == rv_pkg::BRANCH) & ma_wb_i.branch_taken);
    assign target_o   = ma_wb_i.next_pc;

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  rv_pkg::id_ex_t id_ex_i,
    output rv_pkg::ex_ma_t ex_ma_d_o
);

    rv_pkg::opcode_e op;
    rv_pkg::word_t   op_a;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   alu_out;
    logic [32:0]     diff;      // a - b with carry out
    logic            flag_z;
    logic            flag_n;
    logic            flag_v;
    logic            flag_c;
    logic            taken;

    assign op   = rv_pkg::opcode_e'(id_ex_i.instruction[6:2]);
    assign op_a = id_ex_i.rf_r1;
    assign op_b = (op == rv_pkg::OP_IMM) ? rv_pkg::imm_i(id_ex_i.instruction) : id_ex_i.rf_r2;

    // --------------------------------------------------
    // subtraction flags, shared by slt and branches
    // --------------------------------------------------
    assign diff   = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;
    assign flag_z = (diff[31:0] == '0);
    assign flag_n = diff[31];
    assign flag_v = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
    assign flag_c = diff[32];   // set when a >= b unsigned

    always_comb begin
        case (id_ex_i.alu_funct3)
            3'b000: alu_out = id_ex_i.alu_funct7[5] ? diff[31:0] : op_a + op_b;
            3'b001: alu_out = op_a << op_b[4:0];
            3'b010: alu_out = {31'b0, flag_n ^ flag_v}; // slt
            3'b011: alu_out = {31'b0, ~flag_c};         // sltu
            3'b100: alu_out = op_a ^ op_b;
            3'b101: begin
                if (id_ex_i.alu_funct7[5]) begin
                    alu_out = $signed(op_a) >>> op_b[4:0];
                end else begin
                    alu_out = op_a >> op_b[4:0];
                end
            end
            3'b110: alu_out = op_a | op_b;
            default: alu_out = op_a & op_b;
        endcase
    end

    // branch condition by funct3
    always_comb begin
        case (id_ex_i.instruction[14:12])
            3'b000: taken = flag_z;              // beq
            3'b001: taken = ~flag_z;             // bne
            3'b100: taken = flag_n ^ flag_v;     // blt
            3'b101: taken = ~(flag_n ^ flag_v);  // bge
            3'b110: taken = ~flag_c;             // bltu
            3'b111: taken = flag_c;              // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ex_ma_d_o              = '0;
        ex_ma_d_o.instruction  = id_ex_i.instruction;
        ex_ma_d_o.pc           = id_ex_i.pc;
        ex_ma_d_o.rf_r2        = id_ex_i.rf_r2;
        ex_ma_d_o.rd           = id_ex_i.rd;
        ex_ma_d_o.rf_wr        = id_ex_i.rf_wr;
        ex_ma_d_o.mem_rd       = id_ex_i.mem_rd;
        ex_ma_d_o.mem_wr       = id_ex_i.mem_wr;
        ex_ma_d_o.tsize        = id_ex_i.tsize;
        ex_ma_d_o.alu_out      = alu_out;
        ex_ma_d_o.branch_taken = (op == rv_pkg::BRANCH) && taken;
        // rs1 + imm, i-type also serves jalr
        ex_ma_d_o.mem_addr     = id_ex_i.rf_r1 + ((op == rv_pkg::STORE)
                                 ? rv_pkg::imm_s(id_ex_i.instruction)
                                 : rv_pkg::imm_i(id_ex_i.instruction));
    end

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::if_id_t if_id_i,
    input  rv_pkg::id_ex_t id_ex_i,
    input  rv_pkg::ex_ma_t ex_ma_i,
    input  rv_pkg::ma_wb_t ma_wb_i,
    input  rv_pkg::word_t  rf_r1_i,
    input  rv_pkg::word_t  rf_r2_i,
    input  rv_pkg::word_t  wb_data_i,
    input  logic           redirect_i,
    input  logic           mem_busy_i,
    output rv_pkg::id_ex_t id_ex_d_o,
    output logic           flush_o,
    output logic           stall_pc_o,
    output logic           stall_if_id_o,
    output logic           stall_id_ex_o,
    output logic           stall_ex_ma_o,
    output logic           bubble_id_ex_o,
    output logic           bubble_ma_wb_o
);

    logic        ex_ma_alu; // ex_ma result already final
    logic [32:0] res1;      // {unresolved, operand}
    logic [32:0] res2;

    assign ex_ma_alu = rv_pkg::opcode_e'(ex_ma_i.instruction[6:2])
                       inside {rv_pkg::OP, rv_pkg::OP_IMM};

    // youngest producer wins: id_ex, then ex_ma, then ma_wb
    function automatic logic [32:0] resolve(input rv_pkg::reg_addr_t rs,
                                            input rv_pkg::word_t rf_val);
        logic [32:0] r;
        r = {1'b0, rf_val};
        if (rs == '0) begin
            r = {1'b0, rf_val};
        end else if (id_ex_i.rf_wr && id_ex_i.rd == rs) begin
            r = {1'b1, rf_val};                        // not computed yet
        end else if (ex_ma_i.rf_wr && ex_ma_i.rd == rs) begin
            r = ex_ma_alu ? {1'b0, ex_ma_i.alu_out} : {1'b1, rf_val};
        end else if (ma_wb_i.rf_wr && ma_wb_i.rd == rs) begin
            r = {1'b0, wb_data_i};                     // write lands this edge
        end
        return r;
    endfunction

    always_comb begin
        res1 = resolve(if_id_i.rs1, rf_r1_i);
        res2 = resolve(if_id_i.rs2, rf_r2_i);
    end

    always_comb begin
        id_ex_d_o             = '0;
        id_ex_d_o.instruction = if_id_i.instruction;
        id_ex_d_o.pc          = if_id_i.pc;
        id_ex_d_o.rd          = if_id_i.rd;
        id_ex_d_o.rf_wr       = if_id_i.rf_wr;
        id_ex_d_o.mem_rd      = if_id_i.mem_rd;
        id_ex_d_o.mem_wr      = if_id_i.mem_wr;
        id_ex_d_o.tsize       = if_id_i.tsize;
        id_ex_d_o.alu_funct3  = if_id_i.alu_funct3;
        id_ex_d_o.alu_funct7  = if_id_i.alu_funct7;
        id_ex_d_o.rf_r1       = res1[31:0];
        id_ex_d_o.rf_r2       = res2[31:0];
    end

    // --------------------------------------------------
    // stalls chain from the back of the pipe forward
    // --------------------------------------------------
    assign flush_o        = redirect_i;
    assign stall_ex_ma_o  = mem_busy_i;           // hold the access
    assign bubble_ma_wb_o = mem_busy_i;
    assign stall_id_ex_o  = stall_ex_ma_o;
    assign bubble_id_ex_o = (res1[32] | res2[32]) & ~stall_id_ex_o;
    assign stall_if_id_o  = stall_id_ex_o | bubble_id_ex_o;
    assign stall_pc_o     = stall_if_id_o;

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              wr_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     wrdata_i,
    output rv_pkg::word_t     r1_o,
    output rv_pkg::word_t     r2_o
);

    rv_pkg::word_t regs [1:rv_pkg::REG_COUNT-1]; // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && rd_i != '0) begin
            regs[rd_i] <= wrdata_i;
        end
    end

    assign r1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign r2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* source/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall_i,
    input  logic           redirect_i,
    input  rv_pkg::word_t  target_i,
    input  rv_pkg::word_t  imem_rdata_i,
    output rv_pkg::word_t  imem_addr_o,
    output rv_pkg::if_id_t if_id_o
);

    rv_pkg::word_t pc_q;

    // --------------------------------------------------
    // program counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= rv_pkg::RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;          // taken branch or jump from wb
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;      // predict fall-through
        end
    end

    assign imem_addr_o = pc_q;         // memory answers in the same cycle

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb begin
        if_id_o             = '0;
        if_id_o.instruction = imem_rdata_i;
        if_id_o.pc          = pc_q;
        if (imem_rdata_i[1:0] != 2'b11) begin
            if_id_o.instruction = rv_pkg::NOP_INSTR; // not a 32-bit encoding
        end else begin
            case (rv_pkg::opcode_e'(imem_rdata_i[6:2]))
                rv_pkg::LOAD: begin
                    if_id_o.rs1    = imem_rdata_i[19:15];
                    if_id_o.rd     = imem_rdata_i[11:7];
                    if_id_o.rf_wr  = 1'b1;
                    if_id_o.mem_rd = 1'b1;
                    if_id_o.tsize  = rv_pkg::tsize_e'(imem_rdata_i[13:12]);
                end
                rv_pkg::STORE: begin
                    if_id_o.rs1    = imem_rdata_i[19:15];
                    if_id_o.rs2    = imem_rdata_i[24:20];
                    if_id_o.mem_wr = 1'b1;
                    if_id_o.tsize  = rv_pkg::tsize_e'(imem_rdata_i[13:12]);
                end
                rv_pkg::OP_IMM: begin
                    if_id_o.rs1        = imem_rdata_i[19:15];
                    if_id_o.rd         = imem_rdata_i[11:7];
                    if_id_o.rf_wr      = 1'b1;
                    if_id_o.alu_funct3 = imem_rdata_i[14:12];
                    // only srai needs funct7, it sits in the immediate
                    if (imem_rdata_i[14:12] == 3'b101) begin
                        if_id_o.alu_funct7 = imem_rdata_i[31:25];
                    end
                end
                rv_pkg::OP: begin
                    if_id_o.rs1        = imem_rdata_i[19:15];
                    if_id_o.rs2        = imem_rdata_i[24:20];
                    if_id_o.rd         = imem_rdata_i[11:7];
                    if_id_o.rf_wr      = 1'b1;
                    if_id_o.alu_funct3 = imem_rdata_i[14:12];
                    if_id_o.alu_funct7 = imem_rdata_i[31:25];
                end
                rv_pkg::LUI, rv_pkg::AUIPC, rv_pkg::JAL: begin
                    if_id_o.rd    = imem_rdata_i[11:7];
                    if_id_o.rf_wr = 1'b1;   // value formed in wb
                end
                rv_pkg::JALR: begin
                    if_id_o.rs1   = imem_rdata_i[19:15];
                    if_id_o.rd    = imem_rdata_i[11:7];
                    if_id_o.rf_wr = 1'b1;
                end
                rv_pkg::BRANCH: begin
                    if_id_o.rs1        = imem_rdata_i[19:15];
                    if_id_o.rs2        = imem_rdata_i[24:20];
                    if_id_o.alu_funct7 = 7'b0100000; // subtract for the flags
                end
                default: if_id_o.instruction = rv_pkg::NOP_INSTR;
            endcase
        end
    end

endmodule

/* source/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush_i,
    input  logic     stall_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // flush > stall > bubble > load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;            // wrong path, drop it
        end else if (stall_i) begin
            q_o <= q_o;
        end else if (bubble_i) begin
            q_o <= '0;            // all-zero payload is a bubble
        end else begin
            q_o <= d_i;
        end
    end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // major opcode, instruction bits 6..2
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        STORE  = 5'b01000,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } tsize_e;

    // --------------------------------------------------
    // stage payloads
    // --------------------------------------------------
    typedef struct packed {
        word_t     instruction;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rf_wr;
        logic      mem_rd;
        logic      mem_wr;
        tsize_e    tsize;
        logic [2:0] alu_funct3;
        logic [6:0] alu_funct7;
    } if_id_t;

    typedef struct packed {
        word_t     instruction;
        word_t     pc;
        reg_addr_t rd;
        logic      rf_wr;
        logic      mem_rd;
        logic      mem_wr;
        tsize_e    tsize;
        logic [2:0] alu_funct3;
        logic [6:0] alu_funct7;
        word_t     rf_r1; // forwarded operands
        word_t     rf_r2;
    } id_ex_t;

    typedef struct packed {
        word_t     instruction;
        word_t     pc;
        word_t     rf_r2;        // store data
        reg_addr_t rd;
        logic      rf_wr;
        logic      mem_rd;
        logic      mem_wr;
        tsize_e    tsize;
        word_t     alu_out;
        word_t     mem_addr;     // also jalr target before bit 0 clear
        logic      branch_taken;
    } ex_ma_t;

    typedef struct packed {
        word_t     instruction;
        word_t     pc;
        reg_addr_t rd;
        logic      rf_wr;
        word_t     alu_out;
        word_t     mem_rdata;
        logic      branch_taken;
        word_t     next_pc;
    } ma_wb_t;

    // --------------------------------------------------
    // immediates, sign extended
    // --------------------------------------------------
    function automatic word_t imm_i(input word_t ins);
        return {{20{ins[31]}}, ins[31:20]};
    endfunction

    function automatic word_t imm_s(input word_t ins);
        return {{20{ins[31]}}, ins[31:25], ins[11:7]};
    endfunction

    function automatic word_t imm_b(input word_t ins);
        return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    endfunction

    function automatic word_t imm_j(input word_t ins);
        return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    endfunction

    function automatic word_t imm_u(input word_t ins);
        return {ins[31:12], 12'b0};
    endfunction

endpackage
